// File: resamp.f
+incdir+include
rtl/resampRegPkg.sv
rtl/resampDspPkg.sv
rtl/resampRegs.sv
rtl/resampNco.sv
rtl/resampInterp.sv
rtl/auDecimator.sv
rtl/resampTop.sv
sim/resampChecker.sv
sim/resampTop_assert.sv
sim/resampTb.sv

// File: Bender.yml
package:
  name: resamp

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/resampRegPkg.sv
      - rtl/resampDspPkg.sv
      - rtl/resampRegs.sv
      - rtl/resampNco.sv
      - rtl/resampInterp.sv
      - rtl/auDecimator.sv
      - rtl/resampTop.sv
  - target: test
    files:
      - sim/resampChecker.sv
      - sim/resampTop_assert.sv
      - sim/resampTb.sv

// File: sim/resampTb.sv
// Testbench top of the resampler.
// Clock, reset, host programming, input stream, timeout and final verdict.

`timescale 1ns/1ps

module resampTb
    import resampRegPkg::*;
    import resampDspPkg::*;
();

    localparam int FRAC_W      = 8;
    // the tests below take a little over 1000 cycles together.
    localparam int TEST_CYCLES = 1000;
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    logic     clk;
    logic     arstN;
    logic     cs;
    logic     inValid;
    logic     outValid;
    logic     auValid;
    hostAddrT addr;
    hostDataT dataIn;
    hostDataT dataOut;
    byteEnT   wrEn;
    sampleT   inSample;
    sampleT   outSample;
    sampleT   auSample;
    int       errors;
    int       checks;
    int       lastErrors;
    int       cycles;
    int       seed;

    resampTop #(.FRAC_W(FRAC_W)) resampTop_inst (.*);

    resampChecker #(.FRAC_W(FRAC_W)) scoreboard (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    task automatic hostWrite(hostAddrT a, hostDataT d, byteEnT m);
        @(posedge clk);
        cs     <= 1'b1;
        addr   <= a;
        dataIn <= d;
        wrEn   <= m;
        @(posedge clk);
        cs   <= 1'b0;
        wrEn <= '0;
    endtask

    task automatic hostRead(hostAddrT a);
        @(posedge clk);
        cs   <= 1'b1;
        addr <= a;
        wrEn <= '0;
        @(posedge clk);
        cs <= 1'b0;
    endtask

    // density is the chance of an input pulse, out of 256.
    task automatic streamSamples(int n, int density);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            inValid  <= (($random(seed) & 255) < density);
            inSample <= sampleT'($random(seed));
        end
        @(posedge clk);
        inValid <= 1'b0;
        // audio output trails the last input by two cycles.
        repeat (3) @(posedge clk);
    endtask

    task automatic reportTest(string name);
        $display("test %s: %0d errors", name, errors - lastErrors);
        lastErrors = errors;
    endtask

    initial begin
        seed = 32'heca22ce6;
        cycles = 0;
        lastErrors = 0;
        arstN = 1'b1;
        cs = 1'b0;
        addr = '0;
        dataIn = '0;
        wrEn = '0;
        inValid = 1'b0;
        inSample = '0;
        // a clean falling edge resets the flops before the first clock.
        #1 arstN = 1'b0;
        repeat (3) @(posedge clk);
        arstN <= 1'b1;

        for (int a = 0; a < 4; a++) begin
            repeat (3) begin
                hostWrite(hostAddrT'(a), $random(seed), byteEnT'($random(seed)));
                hostRead(hostAddrT'(a));
            end
        end
        repeat (4) hostRead(hostAddrT'(4 + ($random(seed) & 12'hFFF)));
        @(posedge clk);
        addr <= RESAMPLER_RATE;
        reportTest("registers");

        repeat (3) begin
            hostWrite(RESAMPLER_RATE, $random(seed), 4'hF);
            streamSamples(80, 64 + ($random(seed) & 127));
        end
        reportTest("resampling");

        hostWrite(RESAMPLER_RATE, '0, 4'hF);
        streamSamples(50, 200);
        hostWrite(RESAMPLER_RATE, 32'hFFFF_FFFF, 4'hF);
        streamSamples(50, 200);
        reportTest("rate extremes");

        repeat (4) begin
            hostWrite(RESAMPLER_RATE, $random(seed) | 32'h8000_0000, 4'hF);
            hostWrite(RESAMPLER_AURATE, $random(seed), 4'hF);
            hostWrite(RESAMPLER_AUDECIMATION, $unsigned($random(seed)) % 6, 4'hF);
            hostWrite(RESAMPLER_AUSHIFT, $unsigned($random(seed)) % 9, 4'hF);
            streamSamples(100, 220);
        end
        reportTest("audio");

        // rate writes land between and on input pulses.
        for (int i = 0; i < 80; i++) begin
            @(posedge clk);
            inValid  <= 1'($random(seed) & 1);
            inSample <= sampleT'($random(seed));
            cs       <= (i % 4 == 0);
            addr     <= RESAMPLER_RATE;
            dataIn   <= $random(seed);
            wrEn     <= (i % 4 == 0) ? 4'hF : 4'h0;
        end
        streamSamples(0, 0);
        cs   <= 1'b0;
        wrEn <= '0;
        reportTest("reconfiguration");

        hostWrite(RESAMPLER_RATE, 32'hC000_0000, 4'hF);
        for (int i = 0; i < 40; i++) begin
            @(posedge clk);
            inValid  <= 1'b1;
            inSample <= sampleT'($random(seed));
            if (i == 20) arstN <= 1'b0;
            if (i == 23) arstN <= 1'b1;
        end
        streamSamples(0, 0);
        for (int a = 0; a < 4; a++) hostRead(hostAddrT'(a));
        hostWrite(RESAMPLER_RATE, 32'h6000_0000, 4'hF);
        streamSamples(40, 200);
        reportTest("reset");

        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, resampTop_inst.strobeAssert.failCount);
        if (errors == 0 && resampTop_inst.strobeAssert.failCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sim/resampTop_assert.sv
// Bound assertions on the resampler output strobes.
// Output pulses follow an input by the fixed pipeline delay and stay low
// during reset.

`timescale 1ns/1ps

module resampTop_assert (
    input logic clk,
    input logic arstN,
    input logic inValid,
    input logic outValid,
    input logic auValid
);

    int failCount = 0;

    // interpolator output lags the input strobe by one cycle.
    outAfterIn: assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> $past(inValid))
    else begin
        failCount++;
        $error("outValid without an input one cycle earlier");
    end

    // decimator output lags the input strobe by two cycles.
    auAfterIn: assert property (@(posedge clk) disable iff (!arstN)
        auValid |-> $past(inValid, 2))
    else begin
        failCount++;
        $error("auValid without an input two cycles earlier");
    end

    quietInReset: assert property (@(posedge clk) !arstN |-> (!outValid && !auValid))
    else begin
        failCount++;
        $error("output strobe high during reset");
    end

endmodule

bind resampTop resampTop_assert strobeAssert (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (inValid),
    .outValid (outValid),
    .auValid  (auValid)
);

// File: sim/resampChecker.sv
// Reference model and output comparison of the resampler.
// Mirrors the registers, both phase accumulators, the sample history and
// the integrate-and-dump stage, and checks the DUT ports every cycle.

`timescale 1ns/1ps

module resampChecker
    import resampRegPkg::*;
    import resampDspPkg::*;
#(
    parameter int FRAC_W = 8
) (
    input  logic     clk,
    input  logic     arstN,
    input  hostAddrT addr,
    input  hostDataT dataIn,
    input  logic     cs,
    input  byteEnT   wrEn,
    input  hostDataT dataOut,
    input  logic     inValid,
    input  sampleT   inSample,
    input  logic     outValid,
    input  sampleT   outSample,
    input  logic     auValid,
    input  sampleT   auSample,
    output int       errors,
    output int       checks
);

    logic [31:0] regModel [4];
    logic [31:0] phase;
    logic [31:0] auPhase;
    sampleT      lastSample;
    sampleT      expOutSample;
    sampleT      expAuSample;
    logic        expOutValid;
    logic        expAuValid;
    int          accum;
    int          count;

    initial begin
        errors = 0;
        checks = 0;
    end

    // division rounding toward minus infinity.
    function automatic int floorDiv(int num, int den);
        int q;
        q = num / den;
        if ((num % den != 0) && (num < 0)) q = q - 1;
        return q;
    endfunction

    // arithmetic right shift as repeated halving toward minus infinity.
    function automatic int shiftDown(int value, int amount);
        int result;
        result = value;
        for (int i = 0; i < amount; i++) begin
            result = floorDiv(result, 2);
        end
        return result;
    endfunction

    // bits that each register owns.
    function automatic logic [31:0] ownedBits(hostAddrT a);
        case (a)
            RESAMPLER_AUDECIMATION: return 32'h0000_7FFF;
            RESAMPLER_AUSHIFT:      return 32'h0000_003F;
            default:                return 32'hFFFF_FFFF;
        endcase
    endfunction

    function automatic logic [31:0] expectedRead();
        return (cs && int'(addr) < 4) ? regModel[addr[1:0]] : 32'h0;
    endfunction

    task automatic compareValue(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: expected 0x%0h, got 0x%0h at %0t", name, exp, act, $time);
        end
    endtask

    always @(posedge clk) begin
        logic [32:0]       sum;
        logic [FRAC_W-1:0] frac;
        int                prev;
        int                total;
        int                target;
        if (!arstN) begin
            compareValue("outValid", 0, outValid);
            compareValue("auValid", 0, auValid);
            regModel = '{default: '0};
            phase = '0;
            auPhase = '0;
            lastSample = '0;
            accum = 0;
            count = 0;
            expOutValid = 1'b0;
            expAuValid = 1'b0;
        end else begin
            compareValue("outValid", expOutValid, outValid);
            if (expOutValid) compareValue("outSample", expOutSample, outSample);
            compareValue("auValid", expAuValid, auValid);
            if (expAuValid) compareValue("auSample", expAuSample, auSample);
        end
        compareValue("dataOut", expectedRead(), dataOut);
        if (arstN) begin
            // audio stage steps on the resampled output of the last cycle.
            expAuValid = 1'b0;
            if (expOutValid) begin
                sum = {1'b0, auPhase} + {1'b0, regModel[RESAMPLER_AURATE]};
                auPhase = sum[31:0];
                if (sum[32]) begin
                    total = accum + int'(expOutSample);
                    count = count + 1;
                    target = (regModel[RESAMPLER_AUDECIMATION] == 0) ? 1 :
                             int'(regModel[RESAMPLER_AUDECIMATION]);
                    accum = total;
                    if (count >= target) begin
                        expAuValid = 1'b1;
                        expAuSample = sampleT'(shiftDown(total,
                                                         int'(regModel[RESAMPLER_AUSHIFT])));
                        accum = 0;
                        count = 0;
                    end
                end
            end
            expOutValid = 1'b0;
            if (inValid) begin
                sum = {1'b0, phase} + {1'b0, regModel[RESAMPLER_RATE]};
                phase = sum[31:0];
                frac = sum[31 -: FRAC_W];
                if (sum[32]) begin
                    prev = lastSample;
                    expOutValid = 1'b1;
                    expOutSample = sampleT'(prev + floorDiv((int'(inSample) - prev) *
                                                             int'(frac), 1 << FRAC_W));
                end
                lastSample = inSample;
            end
            // a write only takes effect for the next input.
            if (cs && int'(addr) < 4) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (wrEn[lane]) regModel[addr[1:0]][lane*8 +: 8] = dataIn[lane*8 +: 8];
                end
                regModel[addr[1:0]] = regModel[addr[1:0]] & ownedBits(addr);
            end
        end
    end

endmodule

// File: rtl/resampTop.sv
// Top level of the sample-rate converter.
// Host register block, main NCO with linear interpolator, audio NCO with
// integrate-and-dump decimator.

`timescale 1ns/1ps

module resampTop
    import resampRegPkg::*;
    import resampDspPkg::*;
#(
    parameter int FRAC_W = $bits(fracT)
) (
    input  logic     clk,
    input  logic     arstN,
    input  hostAddrT addr,
    input  hostDataT dataIn,
    input  logic     cs,
    input  byteEnT   wrEn,
    output hostDataT dataOut,
    input  logic     inValid,
    input  sampleT   inSample,
    output logic     outValid,
    output sampleT   outSample,
    output logic     auValid,
    output sampleT   auSample
);

    resampCfgT         cfg;
    logic              mainCarry;
    logic [FRAC_W-1:0] mainFrac;
    logic              auCarry;

    resampRegs regs (
        .clk     (clk),
        .arstN   (arstN),
        .addr    (addr),
        .dataIn  (dataIn),
        .cs      (cs),
        .wrEn    (wrEn),
        .dataOut (dataOut),
        .cfg     (cfg)
    );

    // main stage steps once per input sample.
    resampNco #(.FRAC_W(FRAC_W)) mainNco (
        .clk     (clk),
        .arstN   (arstN),
        .advance (inValid),
        .rate    (cfg.resampleRate),
        .carry   (mainCarry),
        .frac    (mainFrac)
    );

    resampInterp #(.FRAC_W(FRAC_W)) interp (
        .clk       (clk),
        .arstN     (arstN),
        .inValid   (inValid),
        .inSample  (inSample),
        .carry     (mainCarry),
        .frac      (mainFrac),
        .outValid  (outValid),
        .outSample (outSample)
    );

    // audio stage steps once per resampled output.
    // it only picks samples, the fractional phase has no use here.
    resampNco #(.FRAC_W(FRAC_W)) auNco (
        .clk     (clk),
        .arstN   (arstN),
        .advance (outValid),
        .rate    (cfg.auResampleRate),
        .carry   (auCarry),
        .frac    ()
    );

    auDecimator decim (
        .clk        (clk),
        .arstN      (arstN),
        .accept     (auCarry),
        .inSample   (outSample),
        .decimation (cfg.auDecimation),
        .shift      (cfg.auShift),
        .auValid    (auValid),
        .auSample   (auSample)
    );

endmodule

// File: rtl/auDecimator.sv
// Integrate-and-dump decimator of the audio stage.
// Sums a programmable number of accepted samples and emits the sum
// shifted right arithmetically and truncated to 16 bits.

`timescale 1ns/1ps

module auDecimator
    import resampRegPkg::*;
    import resampDspPkg::*;
(
    input  logic   clk,
    input  logic   arstN,
    input  logic   accept,
    input  sampleT inSample,
    input  decimT  decimation,
    input  shiftT  shift,
    output logic   auValid,
    output sampleT auSample
);

    accumT accum;
    accumT sumNext;
    decimT count;
    decimT countNext;
    decimT target;
    logic  dump;

    // a decimation of zero behaves as one.
    assign target = (decimation == '0) ? decimT'(1) : decimation;

    assign sumNext   = accum + accumT'(inSample);
    assign countNext = count + decimT'(1);

    // >= also ends a frame cleanly when the decimation is lowered mid-frame.
    assign dump = accept && (countNext >= target);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            accum   <= '0;
            count   <= '0;
            auValid <= 1'b0;
        end else begin
            auValid <= dump;
            if (dump) begin
                accum <= '0;
                count <= '0;
            end else if (accept) begin
                accum <= sumNext;
                count <= countNext;
            end
        end
    end

    // shifted sum, low 16 bits kept.
    always_ff @(posedge clk) begin
        if (dump) begin
            auSample <= sampleT'(sumNext >>> shift);
        end
    end

endmodule

// File: rtl/resampInterp.sv
// Linear interpolator of the main resampling stage.
// Keeps the sample history and registers one weighted sample between the
// two latest inputs for every NCO carry.

`timescale 1ns/1ps

module resampInterp
    import resampDspPkg::*;
#(
    parameter int FRAC_W = $bits(fracT)
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              inValid,
    input  sampleT            inSample,
    input  logic              carry,
    input  logic [FRAC_W-1:0] frac,
    output logic              outValid,
    output sampleT            outSample
);

    // 17-bit difference times an unsigned weight with a sign bit.
    localparam int PROD_W = FRAC_W + 18;

    sampleT                   lastSample;
    logic signed [16:0]       delta;
    logic signed [PROD_W-1:0] weighted;
    logic signed [PROD_W-1:0] step;
    logic signed [16:0]       interpSum;

    // after the shift the history is {lastSample, inSample}.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lastSample <= '0;
        end else if (inValid) begin
            lastSample <= inSample;
        end
    end

    // prev + (cur - prev) * frac / 2^FRAC_W.
    assign delta     = {inSample[15], inSample} - {lastSample[15], lastSample};
    assign weighted  = delta * $signed({1'b0, frac});
    // arithmetic shift rounds toward minus infinity.
    assign step      = weighted >>> FRAC_W;
    assign interpSum = {lastSample[15], lastSample} + step[16:0];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= carry;
        end
    end

    // result lies between the two samples, so 16 bits always hold it.
    always_ff @(posedge clk) begin
        if (carry) begin
            outSample <= interpSum[15:0];
        end
    end

endmodule

// File: rtl/resampNco.sv
// Phase accumulator of the resampler.
// Adds the rate on each advance, flags the carry out of the phase and
// exports the top bits of the new phase as the fractional position.

`timescale 1ns/1ps

module resampNco
    import resampRegPkg::*;
    import resampDspPkg::*;
#(
    parameter int FRAC_W = $bits(fracT)
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              advance,
    input  rateT              rate,
    output logic              carry,
    output logic [FRAC_W-1:0] frac
);

    localparam int PHASE_W = $bits(phaseT);

    phaseT              phase;
    logic [PHASE_W:0]   sum;

    // one extra bit catches the wrap of the phase.
    assign sum = {1'b0, phase} + {1'b0, rate};

    // both come from the sum, in the cycle of the advance.
    assign carry = advance & sum[PHASE_W];
    assign frac  = sum[PHASE_W-1 -: FRAC_W];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phase <= '0;
        end else if (advance) begin
            phase <= sum[PHASE_W-1:0];
        end
    end

endmodule

// File: rtl/resampRegs.sv
// Host register file of the resampler.
// Four configuration registers, byte-lane writes on the clock edge,
// combinational zero-extended readback.

`timescale 1ns/1ps

module resampRegs
    import resampRegPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  hostAddrT  addr,
    input  hostDataT  dataIn,
    input  logic      cs,
    input  byteEnT    wrEn,
    output hostDataT  dataOut,
    output resampCfgT cfg
);

    resampCfgT cfgQ;
    hostDataT  laneMask;

    // one byte of mask per write strobe.
    always_comb begin
        for (int lane = 0; lane < 4; lane++) begin
            laneMask[lane*8 +: 8] = {8{wrEn[lane]}};
        end
    end

    // merge the written lanes over the old word.
    function automatic hostDataT mergeLanes(hostDataT oldWord, hostDataT newWord,
                                            hostDataT mask);
        return (oldWord & ~mask) | (newWord & mask);
    endfunction

    // each register keeps only the bits it owns, so lanes above them drop out.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cfgQ <= '0;
        end else if (cs) begin
            case (addr)
                RESAMPLER_RATE: begin
                    cfgQ.resampleRate <= mergeLanes(cfgQ.resampleRate, dataIn, laneMask);
                end
                RESAMPLER_AURATE: begin
                    cfgQ.auResampleRate <= mergeLanes(cfgQ.auResampleRate, dataIn, laneMask);
                end
                RESAMPLER_AUDECIMATION: begin
                    cfgQ.auDecimation <= decimT'(mergeLanes(hostDataT'(cfgQ.auDecimation),
                                                            dataIn, laneMask));
                end
                RESAMPLER_AUSHIFT: begin
                    cfgQ.auShift <= shiftT'(mergeLanes(hostDataT'(cfgQ.auShift),
                                                       dataIn, laneMask));
                end
                default: begin
                end
            endcase
        end
    end

    // readback, zero when deselected or unmapped.
    always_comb begin
        dataOut = '0;
        if (cs) begin
            case (addr)
                RESAMPLER_RATE:         dataOut = cfgQ.resampleRate;
                RESAMPLER_AURATE:       dataOut = cfgQ.auResampleRate;
                RESAMPLER_AUDECIMATION: dataOut = hostDataT'(cfgQ.auDecimation);
                RESAMPLER_AUSHIFT:      dataOut = hostDataT'(cfgQ.auShift);
                default:                dataOut = '0;
            endcase
        end
    end

    assign cfg = cfgQ;

endmodule

// File: rtl/resampDspPkg.sv
// Data path types of the resampler.
// Samples, accumulator phase, interpolation weight and the
// integrate-and-dump accumulator.

package resampDspPkg;

    // signed two's complement audio sample.
    typedef logic signed [15:0] sampleT;

    // full phase of an NCO.
    typedef logic [31:0] phaseT;

    // top bits of the phase, the interpolation weight.
    // modules size their FRAC_W parameter from this by default.
    typedef logic [7:0] fracT;

    // integrator of the audio decimator.
    // 32 bits hold up to 65536 full-scale samples without wrap.
    typedef logic signed [31:0] accumT;

endpackage

// File: rtl/resampRegPkg.sv
// Host side types of the resampler.
// Bus field widths, configuration field widths, the configuration bundle
// and the register address map.

package resampRegPkg;

    // host bus fields.
    typedef logic [12:0] hostAddrT;
    typedef logic [31:0] hostDataT;
    typedef logic [3:0]  byteEnT;

    // configuration fields.
    typedef logic [31:0] rateT;
    typedef logic [14:0] decimT;
    typedef logic [5:0]  shiftT;

    // everything the data path needs from the register block, 85 bits.
    typedef struct packed {
        rateT  resampleRate;
        rateT  auResampleRate;
        decimT auDecimation;
        shiftT auShift;
    } resampCfgT;

    // word addresses, typed as hostAddrT.
    `include "resampAddrMap.svh"

endpackage

// File: include/resampAddrMap.svh
// Register word addresses of the resampler host block.
// Included inside resampRegPkg, so hostAddrT is already in scope.

`ifndef RESAMP_ADDR_MAP_SVH
`define RESAMP_ADDR_MAP_SVH

// main resampler phase increment.
localparam hostAddrT RESAMPLER_RATE         = hostAddrT'(0);

// audio picker phase increment.
localparam hostAddrT RESAMPLER_AURATE       = hostAddrT'(1);

// audio samples summed per output.
localparam hostAddrT RESAMPLER_AUDECIMATION = hostAddrT'(2);

// arithmetic right shift of the audio sum.
localparam hostAddrT RESAMPLER_AUSHIFT      = hostAddrT'(3);

`endif
